// File: me_top.f
source/me_pkg.sv
source/mem_port_if.sv
source/mem_arbiter.sv
source/block_fetch.sv
source/cur_block_buffer.sv
source/sad_unit.sv
source/me_top.sv
dv/me_top_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the me_top testbench with Verilator, pass is read from sim.log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module me_top_tb \
    -f me_top.f -o me_top_sim \
    && ./obj_dir/me_top_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

// File: dv/me_top_tb.sv
module me_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import me_pkg::*;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  start;
    logic [mem_addr_w-1:0] cur_base;
    logic [mem_addr_w-1:0] ref_base;
    logic                  next_block;
    logic                  mem_rd;
    logic [mem_addr_w-1:0] mem_addr;
    logic [word_w-1:0]     mem_rdata = '0;
    logic                  cur_busy;
    logic                  ref_busy;
    logic [sad_w-1:0]      sad;
    logic                  sad_valid;

    logic [31:0] lfsr = 32'hc63174b4;
    logic [31:0] mem [1024];
    logic [31:0] rd_word;
    int          rd_cnt [1024];
    int          cur_lo;
    int          ref_lo;
    logic [7:0]  cur_m [128]; // Model copy of both current blocks
    logic [7:0]  ref_m [64];
    logic        half;
    logic        old_half;
    int          k;           // Wavefront step, 8 when idle
    int          exp_q1;
    int          exp_q2;
    logic        check_en;
    int          n_val_err = 0;
    int          n_other_err = 0;

    always #2 clk = ~clk;

    me_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .cur_base   (cur_base),
        .ref_base   (ref_base),
        .next_block (next_block),
        .mem_rd     (mem_rd),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .cur_busy   (cur_busy),
        .ref_busy   (ref_busy),
        .sad        (sad),
        .sad_valid  (sad_valid)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic in_range(input int a);
        return (a >= cur_lo && a < cur_lo + cur_words)
            || (a >= ref_lo && a < ref_lo + ref_words);
    endfunction

    // SAD of the block shown this cycle, old half below the diagonal c < r - k
    function automatic int block_sad();
        int   total;
        int   p;
        int   q;
        logic src;
        total = 0;
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                src = (k < 8 && c < r - k) ? old_half : half;
                p = int'(cur_m[int'(src) * 64 + r * 8 + c]);
                q = int'(ref_m[r * 8 + c]);
                total += (p > q) ? p - q : q - p;
            end
        end
        return total;
    endfunction

    // Memory with one cycle read latency, plus address bookkeeping
    always @(posedge clk) begin
        if (mem_rd) begin
            rd_word = mem[mem_addr[9:0]];
            rd_cnt[mem_addr[9:0]] = rd_cnt[mem_addr[9:0]] + 1;
            if (!in_range(int'(mem_addr))) begin
                $display("Error: mem_addr = 0x%h, outside both load ranges", mem_addr);
                n_val_err++;
            end
            #1;
            mem_rdata = rd_word;
        end
    end

    always @(posedge clk) begin
        exp_q2 <= exp_q1;
        exp_q1 <= block_sad();
        if (rst) begin
            half <= 1'b0;
            old_half <= 1'b0;
            k <= 8;
        end else if (next_block) begin
            old_half <= half;
            half <= ~half;
            k <= 0;
        end else if (k < 8) begin
            k <= k + 1;
        end
    end

    always @(negedge clk) begin
        if (check_en) begin
            if (sad_valid !== 1'b1) begin
                $display("Error: sad_valid = 0x%h, expected 0x1", sad_valid);
                n_val_err++;
            end
            if (int'(sad) != exp_q2) begin
                $display("Error: sad = 0x%h, expected 0x%h", sad, exp_q2[sad_w-1:0]);
                n_val_err++;
            end
        end
    end

    task automatic check_low(input string name, input logic v);
        if (v !== 1'b0) begin
            $display("Error: %s = 0x%h, expected 0x0", name, v);
            n_val_err++;
        end
    endtask

    task automatic check_idle();
        check_low("mem_rd", mem_rd);
        check_low("cur_busy", cur_busy);
        check_low("ref_busy", ref_busy);
        check_low("sad_valid", sad_valid);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic start_loads(input int cb, input int rb);
        cur_lo = cb;
        ref_lo = rb;
        for (int i = 0; i < 1024; i++) rd_cnt[i] = 0;
        for (int i = 0; i < 128; i++) cur_m[i] = mem[cb + i / 4][8 * (i % 4) +: 8];
        for (int i = 0; i < 64; i++) ref_m[i] = mem[rb + i / 4][8 * (i % 4) +: 8];
        idle_cycles(1);
        start = 1'b1;
        cur_base = mem_addr_w'(cb);
        ref_base = mem_addr_w'(rb);
        idle_cycles(1);
        start = 1'b0;
    endtask

    task automatic wait_idle(input logic ref_only);
        int n;
        n = 0;
        while ((ref_busy || (!ref_only && cur_busy)) && n < 300) begin
            @(negedge clk);
            n++;
        end
        if (ref_busy || (!ref_only && cur_busy)) begin
            $display("Timeout while waiting for a load to finish");
            n_other_err++;
        end
    endtask

    task automatic wait_sad_valid(input logic level, input int max);
        int n;
        n = 0;
        while (sad_valid !== level && n < max) begin
            @(negedge clk);
            n++;
        end
        if (sad_valid !== level) begin
            $display("Timeout while waiting for sad_valid to become %0d", level);
            n_other_err++;
        end
    endtask

    task automatic check_reads();
        for (int i = 0; i < 1024; i++) begin
            if (in_range(i) && rd_cnt[i] != 1) begin
                $display("Address %0h was read %0d times instead of once", i, rd_cnt[i]);
                n_other_err++;
            end
        end
    endtask

    task automatic pulse_next_block();
        idle_cycles(1);
        next_block = 1'b1;
        idle_cycles(1);
        next_block = 1'b0;
    endtask

    initial begin
        int cb;
        int rb;
        rst = 1'b1;
        start = 1'b0;
        cur_base = '0;
        ref_base = '0;
        next_block = 1'b0;
        check_en = 1'b0;
        for (int i = 0; i < 1024; i++) mem[i] = rand_bits(32);
        repeat (7) begin
            @(negedge clk);
            check_idle();
        end
        idle_cycles(1);
        rst = 1'b0;
        @(negedge clk);
        check_idle();

        // Both loads share the port, ranges kept apart
        cb = int'(rand_bits(9) % 481);
        rb = 512 + int'(rand_bits(9) % 497);
        start_loads(cb, rb);
        wait_idle(1'b0);
        check_reads();

        // Steady left block, then switches and a restarted transition
        idle_cycles(3);
        check_en = 1'b1;
        idle_cycles(16);
        pulse_next_block();
        idle_cycles(12);
        pulse_next_block();
        idle_cycles(12);
        pulse_next_block();
        idle_cycles(3);
        pulse_next_block();
        idle_cycles(14);
        check_en = 1'b0;

        // Reference reload from a new base
        rb = 512 + ((rb - 512 + 1 + int'(rand_bits(8))) % 497);
        start_loads(cb, rb);
        wait_sad_valid(1'b0, 6);
        wait_idle(1'b1);
        wait_sad_valid(1'b1, 4);
        wait_idle(1'b0);
        check_reads();
        idle_cycles(3);
        check_en = 1'b1;
        idle_cycles(20);
        check_en = 1'b0;

        $display("Value errors: %0d, other errors: %0d", n_val_err, n_other_err);
        if (n_val_err + n_other_err == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #50us;
        $display("Simulation ran past its time limit");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: source/me_top.sv
module me_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [me_pkg::mem_addr_w-1:0] cur_base,
    input  logic [me_pkg::mem_addr_w-1:0] ref_base,
    input  logic                          next_block,
    output logic                          mem_rd,
    output logic [me_pkg::mem_addr_w-1:0] mem_addr,
    input  logic [me_pkg::word_w-1:0]     mem_rdata,
    output logic                          cur_busy,
    output logic                          ref_busy,
    output logic [me_pkg::sad_w-1:0]      sad,
    output logic                          sad_valid
);
    import me_pkg::*;

    mem_port_if cur_port ();
    mem_port_if ref_port ();

    logic                cur_wr_en;
    logic [word_w-1:0]   cur_wr_data;
    logic                ref_wr_en;
    logic [word_w-1:0]   ref_wr_data;
    logic [blk_bits-1:0] cur_pix;

    mem_arbiter i_arbiter (
        .clk       (clk),
        .rst       (rst),
        .cur       (cur_port.arbiter),
        .ref_p     (ref_port.arbiter),
        .mem_rd    (mem_rd),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata)
    );

    block_fetch #(.n_words(cur_words)) cur_fetch (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .base    (cur_base),
        .port    (cur_port.requester),
        .busy    (cur_busy),
        .wr_en   (cur_wr_en),
        .wr_data (cur_wr_data)
    );

    block_fetch #(.n_words(ref_words)) ref_fetch (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .base    (ref_base),
        .port    (ref_port.requester),
        .busy    (ref_busy),
        .wr_en   (ref_wr_en),
        .wr_data (ref_wr_data)
    );

    cur_block_buffer i_cur_buf (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .next_block (next_block),
        .wr_en      (cur_wr_en),
        .wr_data    (cur_wr_data),
        .cur_pix    (cur_pix)
    );

    sad_unit i_sad (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .wr_en     (ref_wr_en),
        .wr_data   (ref_wr_data),
        .cur_pix   (cur_pix),
        .sad       (sad),
        .sad_valid (sad_valid)
    );

endmodule

// File: source/sad_unit.sv
module sad_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        wr_en,
    input  logic [me_pkg::word_w-1:0]   wr_data,
    input  logic [me_pkg::blk_bits-1:0] cur_pix,
    output logic [me_pkg::sad_w-1:0]    sad,
    output logic                        sad_valid
);
    import me_pkg::*;

    logic [pix_w-1:0]              ref_mem [blk_dim*blk_dim];
    logic [$clog2(ref_words)-1:0]  fill_cnt;
    logic                          ready;

    logic [row_sum_w-1:0] row_sum   [blk_dim];
    logic [row_sum_w-1:0] row_sum_q [blk_dim];
    logic                 valid_q;
    logic [sad_w-1:0]     total;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_cnt <= '0;
            ready    <= 1'b0;
        end else if (start) begin
            fill_cnt <= '0;
            ready    <= 1'b0;
        end else if (wr_en) begin
            fill_cnt <= fill_cnt + 1'b1;
            if (fill_cnt == $bits(fill_cnt)'(ref_words - 1)) begin
                ready <= 1'b1; // Sixteenth word in
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < word_pix; b++) begin
                ref_mem[int'(fill_cnt)*word_pix + b] <= wr_data[b*pix_w +: pix_w];
            end
        end
    end

    always_comb begin
        logic [pix_w-1:0] a;
        logic [pix_w-1:0] b;
        for (int r = 0; r < blk_dim; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < blk_dim; c++) begin
                a = cur_pix[r*blk_dim*pix_w + (blk_dim-1-c)*pix_w +: pix_w];
                b = ref_mem[r*blk_dim + c];
                row_sum[r] = row_sum[r] + row_sum_w'((a > b) ? a - b : b - a);
            end
        end
    end

    always_comb begin
        total = '0;
        for (int r = 0; r < blk_dim; r++) begin
            total = total + sad_w'(row_sum_q[r]);
        end
    end

    // Two stages, row sums then their total
    always_ff @(posedge clk) begin
        row_sum_q <= row_sum;
        sad       <= total;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q   <= 1'b0;
            sad_valid <= 1'b0;
        end else begin
            valid_q   <= ready;
            sad_valid <= valid_q;
        end
    end

endmodule

// File: source/cur_block_buffer.sv
module cur_block_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        next_block,
    input  logic                        wr_en,
    input  logic [me_pkg::word_w-1:0]   wr_data,
    output logic [me_pkg::blk_bits-1:0] cur_pix
);
    import me_pkg::*;

    // Left block at 0..63, right block at 64..127, both row-major
    logic [pix_w-1:0] pix_mem [2*blk_dim*blk_dim];

    logic [$clog2(2*blk_dim*blk_dim)-1:0] wr_ptr;

    logic       half;     // Set selects the right block
    logic       in_trans;
    logic [2:0] step;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (start) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + $bits(wr_ptr)'(word_pix);
        end
    end

    // Byte 0 lands at the lowest address
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < word_pix; b++) begin
                pix_mem[int'(wr_ptr) + b] <= wr_data[b*pix_w +: pix_w];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            half     <= 1'b0;
            in_trans <= 1'b0;
            step     <= '0;
        end else if (next_block) begin
            // Also restarts a transition already running
            half     <= ~half;
            in_trans <= 1'b1;
            step     <= '0;
        end else if (in_trans) begin
            step <= step + 1'b1;
            if (step == 3'd7) begin
                in_trans <= 1'b0;
            end
        end
    end

    // Diagonal wavefront, the new block sweeps in from the upper right
    for (genvar r = 0; r < blk_dim; r++) begin : g_row
        for (genvar c = 0; c < blk_dim; c++) begin : g_col
            logic use_old;
            logic from_right;

            // Old half still shown below the diagonal c < r - k
            assign use_old    = in_trans && (int'(step) + c < r);
            assign from_right = half ^ use_old;

            // Row 0 in the low bits, column 0 in the top byte of a row
            assign cur_pix[r*blk_dim*pix_w + (blk_dim-1-c)*pix_w +: pix_w] =
                from_right ? pix_mem[blk_dim*blk_dim + r*blk_dim + c]
                           : pix_mem[r*blk_dim + c];
        end
    end

endmodule

// File: source/block_fetch.sv
module block_fetch #(
    parameter int n_words = me_pkg::cur_words
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [me_pkg::mem_addr_w-1:0] base,
    mem_port_if.requester                 port,
    output logic                          busy,
    output logic                          wr_en,
    output logic [me_pkg::word_w-1:0]     wr_data
);
    import me_pkg::*;

    fetch_state_t                 state;
    logic [mem_addr_w-1:0]        addr_q;
    logic [$clog2(n_words)-1:0]   cnt;    // Words granted so far

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= fetch_idle;
            addr_q <= '0;
            cnt    <= '0;
        end else if (start) begin
            state  <= fetch_busy;
            addr_q <= base;
            cnt    <= '0;
        end else begin
            case (state)
                fetch_busy: begin
                    if (port.gnt) begin
                        addr_q <= addr_q + 1'b1;
                        cnt    <= cnt + 1'b1;
                        if (cnt == $bits(cnt)'(n_words - 1)) begin
                            state <= fetch_drain;
                        end
                    end
                end
                fetch_drain: begin
                    // Last word arrives one cycle after its grant
                    if (port.rvalid) begin
                        state <= fetch_idle;
                    end
                end
                default: state <= fetch_idle;
            endcase
        end
    end

    assign port.req  = (state == fetch_busy);
    assign port.addr = addr_q; // Held while losing arbitration
    assign busy      = (state != fetch_idle);

    assign wr_en   = port.rvalid;
    assign wr_data = port.rdata;

endmodule

// File: source/mem_arbiter.sv
module mem_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    mem_port_if.arbiter                   cur,
    mem_port_if.arbiter                   ref_p,
    output logic                          mem_rd,
    output logic [me_pkg::mem_addr_w-1:0] mem_addr,
    input  logic [me_pkg::word_w-1:0]     mem_rdata
);

    logic last_was_ref; // Set means cur goes first on a tie
    logic cur_win;
    logic ref_win;
    logic cur_gnt_q;
    logic ref_gnt_q;

    // Round robin between the two requesters
    assign cur_win = cur.req && (!ref_p.req || last_was_ref);
    assign ref_win = ref_p.req && !cur_win;

    assign cur.gnt   = cur_win;
    assign ref_p.gnt = ref_win;

    assign mem_rd   = cur_win || ref_win;
    assign mem_addr = ref_win ? ref_p.addr : cur.addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_was_ref <= 1'b1;
            cur_gnt_q    <= 1'b0;
            ref_gnt_q    <= 1'b0;
        end else begin
            cur_gnt_q <= cur_win;
            ref_gnt_q <= ref_win;
            if (cur_win) begin
                last_was_ref <= 1'b0;
            end else if (ref_win) begin
                last_was_ref <= 1'b1;
            end
        end
    end

    // Returning word goes to whoever was granted last cycle
    assign cur.rvalid   = cur_gnt_q;
    assign ref_p.rvalid = ref_gnt_q;
    assign cur.rdata    = mem_rdata;
    assign ref_p.rdata  = mem_rdata;

endmodule

// File: source/mem_port_if.sv
interface mem_port_if;
    import me_pkg::*;

    logic                  req;
    logic [mem_addr_w-1:0] addr;
    logic                  gnt;    // Same cycle as req
    logic [word_w-1:0]     rdata;
    logic                  rvalid; // One cycle after gnt

    modport requester (
        output req, addr,
        input  gnt, rdata, rvalid
    );

    modport arbiter (
        input  req, addr,
        output gnt, rdata, rvalid
    );

endinterface

// File: source/me_pkg.sv
package me_pkg;

    localparam int pix_w      = 8;
    localparam int blk_dim    = 8;
    localparam int word_pix   = 4;
    localparam int word_w     = word_pix * pix_w;         // One memory word
    localparam int blk_bits   = blk_dim * blk_dim * pix_w; // Whole 8x8 block
    localparam int mem_addr_w = 16;

    // Load lengths in words
    localparam int cur_words = 2 * blk_dim * blk_dim / word_pix;
    localparam int ref_words = blk_dim * blk_dim / word_pix;

    // Row of eight diffs fits in 11 bits, 64 of them in 14
    localparam int row_sum_w = pix_w + 3;
    localparam int sad_w     = 14;

    // States of the fetch sequencer
    typedef enum logic [1:0] {
        fetch_idle,
        fetch_busy,
        fetch_drain
    } fetch_state_t;

endpackage
